// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;     // Data or byte address word.
    typedef logic [4:0]  reg_addr_t; // Index into the register file.

    // Primary opcodes in bits 31:26 of the instruction.
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // Function codes in bits 5:0 when the opcode is op_special.
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_mem,
        st_writeback,
        st_halt
    } cpu_state_t;

    localparam word_t halt_addr = 32'h0000_0000; // A JR here stops the core after its delay slot.

endpackage

`default_nettype wire

// File: mips_alu.sv
`default_nettype none

module mips_alu (
    input  mips_pkg::alu_op_t alu_op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    input  logic              shift_by_reg,
    output mips_pkg::word_t   result
);

    logic [4:0] shift_amount;

    // Variable shifts take their distance from rs, which arrives on a.
    assign shift_amount = shift_by_reg ? a[4:0] : shamt;

    always_comb begin
        case (alu_op)
            mips_pkg::alu_add: result = a + b; // Also forms the LW and SW address.
            mips_pkg::alu_sub: result = a - b;
            mips_pkg::alu_and: result = a & b;
            mips_pkg::alu_or:  result = a | b;
            mips_pkg::alu_xor: result = a ^ b;
            mips_pkg::alu_sll: result = b << shift_amount;
            mips_pkg::alu_srl: result = b >> shift_amount; // Logical, so zeros fill from the top.
            default:           result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// File: mips_regfile.sv
`default_nettype none

module mips_regfile (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  logic                wr_en,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     v0
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data; // Register 0 never changes.
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[2]; // Register 2 is v0 in the MIPS convention.

endmodule

`default_nettype wire

// File: mips_pc.sv
`default_nettype none

module mips_pc #(
    parameter mips_pkg::word_t reset_vector = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            pc_advance,
    input  logic            jump_take,
    input  mips_pkg::word_t jump_target,
    output mips_pkg::word_t pc,
    output logic            halt_req
);

    mips_pkg::word_t npc;
    logic            halt_armed;

    // The pc names the next word to fetch and npc the one after it, so a
    // jump only replaces npc and the delay slot is still fetched from pc.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= reset_vector;
            npc        <= reset_vector + 32'd4;
            halt_armed <= 1'b0;
            halt_req   <= 1'b0;
        end else if (pc_advance) begin
            pc         <= npc;
            npc        <= jump_take ? jump_target : npc + 32'd4;
            halt_armed <= jump_take && (jump_target == mips_pkg::halt_addr);
            halt_req   <= halt_armed; // Set while the delay slot is in flight.
        end
    end

endmodule

`default_nettype wire

// File: mips_fsm.sv
`default_nettype none

module mips_fsm (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [5:0]           opcode,
    input  logic [5:0]           funct,
    input  logic                 waitrequest,
    input  logic                 halt_req,
    output mips_pkg::cpu_state_t state,
    output logic                 read,
    output logic                 write,
    output logic                 ir_load,
    output logic                 mdr_load,
    output logic                 pc_advance,
    output logic                 jump_take,
    output logic                 rf_write,
    output logic                 rf_dst_rt,
    output mips_pkg::alu_op_t    alu_op,
    output logic                 alu_src_imm,
    output logic                 imm_zero_ext,
    output logic                 shift_by_reg,
    output logic                 active
);

    mips_pkg::cpu_state_t state_next;
    mips_pkg::cpu_state_t retire_state;
    logic is_special;
    logic is_lw;
    logic is_sw;
    logic is_jr;
    logic writes_reg;
    logic bus_done;

    always_comb begin
        is_special   = (opcode == mips_pkg::op_special);
        is_lw        = (opcode == mips_pkg::op_lw);
        is_sw        = (opcode == mips_pkg::op_sw);
        is_jr        = is_special && (funct == mips_pkg::fn_jr);
        alu_op       = mips_pkg::alu_add;
        alu_src_imm  = !is_special;
        imm_zero_ext = 1'b0;
        shift_by_reg = 1'b0;
        writes_reg   = 1'b1; // Cleared below for SW, JR and unknown codes.
        if (is_special) begin
            case (funct)
                mips_pkg::fn_sll:  alu_op = mips_pkg::alu_sll;
                mips_pkg::fn_srl:  alu_op = mips_pkg::alu_srl;
                mips_pkg::fn_sllv: begin
                    alu_op       = mips_pkg::alu_sll;
                    shift_by_reg = 1'b1;
                end
                mips_pkg::fn_srlv: begin
                    alu_op       = mips_pkg::alu_srl;
                    shift_by_reg = 1'b1;
                end
                mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
                mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
                mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
                mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
                mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
                default:           writes_reg = 1'b0; // JR lands here too.
            endcase
        end else begin
            case (opcode)
                mips_pkg::op_addiu: alu_op = mips_pkg::alu_add;
                mips_pkg::op_andi: begin
                    alu_op       = mips_pkg::alu_and;
                    imm_zero_ext = 1'b1; // Logical immediates are zero extended.
                end
                mips_pkg::op_ori: begin
                    alu_op       = mips_pkg::alu_or;
                    imm_zero_ext = 1'b1;
                end
                mips_pkg::op_xori: begin
                    alu_op       = mips_pkg::alu_xor;
                    imm_zero_ext = 1'b1;
                end
                mips_pkg::op_lw:    alu_op = mips_pkg::alu_add;
                default:            writes_reg = 1'b0; // SW computes an address only.
            endcase
        end
    end

    assign bus_done     = (read || write) && !waitrequest;
    assign retire_state = halt_req ? mips_pkg::st_halt : mips_pkg::st_fetch;

    always_comb begin
        state_next = state;
        case (state)
            mips_pkg::st_fetch:     if (bus_done) state_next = mips_pkg::st_decode;
            mips_pkg::st_decode:    state_next = mips_pkg::st_exec;
            mips_pkg::st_exec:      state_next = (is_lw || is_sw) ? mips_pkg::st_mem
                                                                  : mips_pkg::st_writeback;
            mips_pkg::st_mem: begin
                if (bus_done) begin
                    state_next = is_lw ? mips_pkg::st_writeback : retire_state;
                end
            end
            mips_pkg::st_writeback: state_next = retire_state;
            default:                state_next = mips_pkg::st_halt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= mips_pkg::st_fetch;
            read   <= 1'b0;
            write  <= 1'b0;
            active <= 1'b1;
        end else begin
            state  <= state_next;
            read   <= (state_next == mips_pkg::st_fetch) ||
                      ((state_next == mips_pkg::st_mem) && is_lw);
            write  <= (state_next == mips_pkg::st_mem) && is_sw;
            active <= active && (state_next != mips_pkg::st_halt);
        end
    end

    assign ir_load    = (state == mips_pkg::st_fetch) && bus_done;
    assign mdr_load   = (state == mips_pkg::st_mem) && read && !waitrequest;
    assign pc_advance = (state == mips_pkg::st_decode); // PC moves on once the IR holds the word.
    assign jump_take  = (state == mips_pkg::st_decode) && is_jr;
    assign rf_write   = (state == mips_pkg::st_writeback) && writes_reg;
    assign rf_dst_rt  = !is_special; // Immediate forms write rt instead of rd.

endmodule

`default_nettype wire

// File: mips_cpu.sv
`default_nettype none

module mips_cpu #(
    parameter mips_pkg::word_t reset_vector = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst,
    output logic            active,
    output mips_pkg::word_t register_v0,
    output mips_pkg::word_t address,
    output logic            read,
    output logic            write,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata,
    input  logic            waitrequest
);

    mips_pkg::cpu_state_t state;
    mips_pkg::alu_op_t    alu_op;
    mips_pkg::word_t      ir;
    mips_pkg::word_t      mdr;
    mips_pkg::word_t      rs_val;
    mips_pkg::word_t      rt_val;
    mips_pkg::word_t      rs_data;
    mips_pkg::word_t      rt_data;
    mips_pkg::word_t      pc;
    mips_pkg::word_t      imm_ext;
    mips_pkg::word_t      alu_b;
    mips_pkg::word_t      alu_result;
    mips_pkg::word_t      wr_data;
    mips_pkg::reg_addr_t  wr_addr;
    logic ir_load;
    logic mdr_load;
    logic pc_advance;
    logic jump_take;
    logic halt_req;
    logic rf_write;
    logic rf_dst_rt;
    logic alu_src_imm;
    logic imm_zero_ext;
    logic shift_by_reg;
    logic bus_hold;

    always_ff @(posedge clk) begin
        if (ir_load) ir <= readdata;   // Instruction word arrives on the fetch handshake.
        if (mdr_load) mdr <= readdata; // Load data arrives on the memory handshake.
        if (state == mips_pkg::st_decode) begin
            rs_val <= rs_data;
            rt_val <= rt_data;
        end
    end

    // The bus registers reload on every edge except while a transfer is stalled.
    assign bus_hold = (read || write) && waitrequest;

    always_ff @(posedge clk) begin
        if (!bus_hold) begin
            address   <= (state == mips_pkg::st_exec) ? alu_result : pc;
            writedata <= rt_val;
        end
    end

    assign byteenable = 4'b1111;

    assign imm_ext = imm_zero_ext ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    assign alu_b   = alu_src_imm ? imm_ext : rt_val;
    assign wr_addr = rf_dst_rt ? ir[20:16] : ir[15:11];
    assign wr_data = (ir[31:26] == mips_pkg::op_lw) ? mdr : alu_result;

    mips_fsm u_fsm (
        .clk          (clk),
        .rst          (rst),
        .opcode       (ir[31:26]),
        .funct        (ir[5:0]),
        .waitrequest  (waitrequest),
        .halt_req     (halt_req),
        .state        (state),
        .read         (read),
        .write        (write),
        .ir_load      (ir_load),
        .mdr_load     (mdr_load),
        .pc_advance   (pc_advance),
        .jump_take    (jump_take),
        .rf_write     (rf_write),
        .rf_dst_rt    (rf_dst_rt),
        .alu_op       (alu_op),
        .alu_src_imm  (alu_src_imm),
        .imm_zero_ext (imm_zero_ext),
        .shift_by_reg (shift_by_reg),
        .active       (active)
    );

    mips_pc #(
        .reset_vector (reset_vector)
    ) u_pc (
        .clk         (clk),
        .rst         (rst),
        .pc_advance  (pc_advance),
        .jump_take   (jump_take),
        .jump_target (rs_data), // JR resolves in decode, straight from the register file.
        .pc          (pc),
        .halt_req    (halt_req)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (ir[25:21]),
        .rt_addr (ir[20:16]),
        .wr_en   (rf_write),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    mips_alu u_alu (
        .alu_op       (alu_op),
        .a            (rs_val),
        .b            (alu_b),
        .shamt        (ir[10:6]),
        .shift_by_reg (shift_by_reg),
        .result       (alu_result)
    );

endmodule

`default_nettype wire

// File: avalon_ram_model.sv
`default_nettype none

module avalon_ram_model #(
    parameter int unsigned depth = 1024,
    parameter int          seed  = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall_en,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    input  logic [3:0]      byteenable,
    output mips_pkg::word_t readdata,
    output logic            waitrequest
);

    timeunit 1ns;
    timeprecision 1ps;

    mips_pkg::word_t mem [depth];
    logic [1:0]      stall_left = 2'd0; // Wait cycles still owed to the next transfer.
    bit              seeded = 1'b0;
    int              rng_seed = seed;
    int unsigned     draw;

    function automatic int unsigned word_index(input mips_pkg::word_t addr);
        return (addr >> 2) % depth; // Word addressed, so the two low bits are dropped.
    endfunction

    task automatic clear_words();
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    endtask

    task automatic load_word(input mips_pkg::word_t addr, input mips_pkg::word_t data);
        mem[word_index(addr)] = data;
    endtask

    function automatic mips_pkg::word_t peek_word(input mips_pkg::word_t addr);
        return mem[word_index(addr)];
    endfunction

    always @(posedge clk) begin
        if (!seeded) begin
            draw   = $urandom(rng_seed); // Seeds the random stream of this process.
            seeded = 1'b1;
        end
        if (rst) begin
            stall_left <= 2'd0;
        end else if ((read || write) && (stall_left != 2'd0)) begin
            stall_left <= stall_left - 2'd1;
        end else if (read || write) begin
            if (write) begin
                for (int b = 0; b < 4; b++) begin
                    if (byteenable[b]) begin
                        mem[word_index(address)][8*b +: 8] = writedata[8*b +: 8];
                    end
                end
            end
            draw       = $urandom;
            stall_left <= stall_en ? draw[1:0] : 2'd0; // Stall of the following transfer.
        end
    end

    assign waitrequest = (stall_left != 2'd0);
    assign readdata    = mem[word_index(address)];

endmodule

`default_nettype wire

// File: mips_cpu_assertions.sv
`default_nettype none

module mips_cpu_assertions (
    input logic                 clk,
    input logic                 rst,
    input logic                 read,
    input logic                 write,
    input logic                 waitrequest,
    input logic                 active,
    input mips_pkg::word_t      address,
    input mips_pkg::word_t      writedata,
    input mips_pkg::cpu_state_t state
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned failures = 0;

    bus_held_in_stall: assert property (@(posedge clk) disable iff (rst)
        (read || write) && waitrequest |=> $stable(address) && $stable(writedata) &&
                                           $stable(read) && $stable(write))
        else begin
            failures++;
            $error("Bus outputs changed while waitrequest was high.");
        end

    no_read_with_write: assert property (@(posedge clk) disable iff (rst) !(read && write))
        else begin
            failures++;
            $error("Read and write were high together.");
        end

    reset_state: assert property (@(posedge clk)
        rst |=> !read && !write && active && (state == mips_pkg::st_fetch))
        else begin
            failures++;
            $error("Reset did not leave the core idle in the fetch state.");
        end

endmodule

`default_nettype wire

// File: mips_cpu_tb.sv
`default_nettype none

module mips_cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // Programs start where the halting jump points, so JR $zero ends them.
    localparam mips_pkg::word_t reset_vector   = mips_pkg::halt_addr;
    localparam int              timeout_cycles = 2000;

    logic            clk = 1'b0;
    logic            rst = 1'b1;
    logic            stall_en = 1'b0;
    logic            active;
    mips_pkg::word_t register_v0;
    mips_pkg::word_t address;
    logic            read;
    logic            write;
    mips_pkg::word_t writedata;
    logic [3:0]      byteenable;
    mips_pkg::word_t readdata;
    logic            waitrequest;
    int unsigned     stall_cycles = 0;

    always #10 clk = ~clk;

    mips_cpu #(
        .reset_vector (reset_vector)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    avalon_ram_model #(
        .seed (64249)
    ) u_ram (
        .clk         (clk),
        .rst         (rst),
        .stall_en    (stall_en),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    bind mips_cpu mips_cpu_assertions u_assertions (
        .clk         (clk),
        .rst         (rst),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .active      (active),
        .address     (address),
        .writedata   (writedata),
        .state       (state)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t actual,
                              input mips_pkg::word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0d ns: %s is 0x%08h, expected 0x%08h",
                                $time, name, actual, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0d ns: %s is %b, expected %b",
                                $time, name, actual, expected));
        end
    endtask

    always @(negedge clk) begin
        if (u_dut.u_assertions.failures != 0) begin
            abort_run("A bus protocol assertion failed.");
        end
    end

    always @(posedge clk) begin
        if ((read || write) && waitrequest) begin
            stall_cycles <= stall_cycles + 1; // Shows that the stall pass really stalled.
        end
    end

    function automatic mips_pkg::word_t encode_itype(input logic [5:0] op, input int rs,
                                                     input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic mips_pkg::word_t encode_rtype(input int rs, input int rt, input int rd,
                                                     input int shamt, input logic [5:0] fn);
        return {mips_pkg::op_special, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
    endfunction

    // Code goes at the reset vector and two operand words at 0x100 and 0x104.
    task automatic load_program(input mips_pkg::word_t words[$], input mips_pkg::word_t a,
                                input mips_pkg::word_t b);
        u_ram.clear_words();
        foreach (words[i]) begin
            u_ram.load_word(reset_vector + 32'(4 * i), words[i]);
        end
        u_ram.load_word(32'h0000_0100, a);
        u_ram.load_word(32'h0000_0104, b);
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit("read", read, 1'b0);
        check_bit("write", write, 1'b0);
        check_bit("active", active, 1'b1);
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit("read", read, 1'b1); // First fetch starts on the edge after reset.
        check_word("address", address, reset_vector);
    endtask

    task automatic wait_halt();
        int cycles;
        for (cycles = 0; (cycles < timeout_cycles) && active; cycles++) begin
            @(negedge clk);
        end
        if (active) begin
            abort_run("Timeout: the processor did not halt within 2000 cycles.");
        end
    endtask

    task automatic run_program(input mips_pkg::word_t words[$], input mips_pkg::word_t a,
                               input mips_pkg::word_t b);
        load_program(words, a, b);
        reset_dut();
        wait_halt();
    endtask

    task automatic test_reference();
        mips_pkg::word_t prog[$];
        prog = {encode_itype(mips_pkg::op_addiu, 0, 2, 16'h0200),
                encode_itype(mips_pkg::op_addiu, 0, 3, 16'h0008),
                encode_rtype(3, 2, 2, 0, mips_pkg::fn_srlv),
                encode_rtype(0, 0, 0, 0, mips_pkg::fn_jr),
                32'h0000_0000};
        run_program(prog, '0, '0);
        check_word("register_v0", register_v0, 32'h0000_0200 >> 8);
        repeat (4) @(negedge clk);
        check_bit("active", active, 1'b0); // Stays low until the next reset.
    endtask

    task automatic run_alu_case(input string name, input mips_pkg::word_t instr,
                                input mips_pkg::word_t a, input mips_pkg::word_t b,
                                input mips_pkg::word_t expected);
        mips_pkg::word_t prog[$];
        prog = {encode_itype(mips_pkg::op_lw, 0, 8, 16'h0100),
                encode_itype(mips_pkg::op_lw, 0, 9, 16'h0104),
                instr,
                encode_rtype(0, 0, 0, 0, mips_pkg::fn_jr),
                32'h0000_0000};
        run_program(prog, a, b);
        check_word(name, register_v0, expected);
    endtask

    task automatic test_alu_ops();
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        logic [15:0]     imm;
        a   = 32'h9abc_def3;
        b   = 32'h1357_9bdf;
        imm = 16'h8421; // Top bit set, so sign and zero extension differ.
        run_alu_case("v0 after addiu", encode_itype(mips_pkg::op_addiu, 8, 2, imm), a, b,
                     a + {{16{imm[15]}}, imm});
        run_alu_case("v0 after andi", encode_itype(mips_pkg::op_andi, 8, 2, imm), a, b,
                     a & {16'h0000, imm});
        run_alu_case("v0 after ori", encode_itype(mips_pkg::op_ori, 8, 2, imm), a, b,
                     a | {16'h0000, imm});
        run_alu_case("v0 after xori", encode_itype(mips_pkg::op_xori, 8, 2, imm), a, b,
                     a ^ {16'h0000, imm});
        run_alu_case("v0 after addu", encode_rtype(8, 9, 2, 0, mips_pkg::fn_addu), a, b, a + b);
        run_alu_case("v0 after subu", encode_rtype(8, 9, 2, 0, mips_pkg::fn_subu), a, b, a - b);
        run_alu_case("v0 after and", encode_rtype(8, 9, 2, 0, mips_pkg::fn_and), a, b, a & b);
        run_alu_case("v0 after or", encode_rtype(8, 9, 2, 0, mips_pkg::fn_or), a, b, a | b);
        run_alu_case("v0 after xor", encode_rtype(8, 9, 2, 0, mips_pkg::fn_xor), a, b, a ^ b);
        run_alu_case("v0 after sll", encode_rtype(0, 9, 2, 7, mips_pkg::fn_sll), a, b, b << 7);
        run_alu_case("v0 after srl", encode_rtype(0, 9, 2, 13, mips_pkg::fn_srl), a, b, b >> 13);
        run_alu_case("v0 after sllv", encode_rtype(8, 9, 2, 0, mips_pkg::fn_sllv), a, b,
                     b << a[4:0]);
        run_alu_case("v0 after srlv", encode_rtype(8, 9, 2, 0, mips_pkg::fn_srlv), a, b,
                     b >> a[4:0]);
    endtask

    task automatic test_load_store();
        mips_pkg::word_t prog[$];
        mips_pkg::word_t data;
        mips_pkg::word_t store_addr;
        data       = 32'hcafe_f00d;
        store_addr = 32'h0000_0244 + {{16{1'b1}}, 16'hfffc}; // Base plus offset -4.
        prog = {encode_itype(mips_pkg::op_lw, 0, 8, 16'h0100),
                encode_itype(mips_pkg::op_addiu, 0, 9, 16'h0244),
                encode_itype(mips_pkg::op_sw, 9, 8, 16'hfffc),
                encode_itype(mips_pkg::op_lw, 9, 2, 16'hfffc),
                encode_rtype(0, 0, 0, 0, mips_pkg::fn_jr),
                32'h0000_0000};
        run_program(prog, data, '0);
        check_word("memory word at 0x240", u_ram.peek_word(store_addr), data);
        check_word("register_v0", register_v0, data);
    endtask

    task automatic test_delay_slot();
        mips_pkg::word_t prog[$];
        prog = {encode_itype(mips_pkg::op_addiu, 0, 2, 16'd5),
                encode_rtype(0, 0, 0, 0, mips_pkg::fn_jr),
                encode_itype(mips_pkg::op_addiu, 2, 2, 16'd7),
                encode_itype(mips_pkg::op_addiu, 2, 2, 16'd100)};
        run_program(prog, '0, '0);
        check_word("register_v0", register_v0, 32'd12);
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_bit("read", read, 1'b0);
            check_bit("write", write, 1'b0);
            check_bit("active", active, 1'b0);
        end
        // A jump to 0x20 still runs its delay slot and skips the word after it.
        prog = {encode_itype(mips_pkg::op_addiu, 0, 9, 16'h0020),
                encode_rtype(9, 0, 0, 0, mips_pkg::fn_jr),
                encode_itype(mips_pkg::op_addiu, 0, 2, 16'h0001),
                encode_itype(mips_pkg::op_addiu, 2, 2, 16'h0040),
                32'h0, 32'h0, 32'h0, 32'h0,
                encode_itype(mips_pkg::op_addiu, 2, 2, 16'h0010),
                encode_rtype(0, 0, 0, 0, mips_pkg::fn_jr),
                32'h0000_0000};
        run_program(prog, '0, '0);
        check_word("register_v0", register_v0, 32'h0000_0011);
    endtask

    task automatic test_reset_mid_run();
        mips_pkg::word_t prog[$];
        prog = {encode_itype(mips_pkg::op_addiu, 0, 2, 16'h0200),
                encode_itype(mips_pkg::op_addiu, 0, 3, 16'h0008),
                encode_rtype(3, 2, 2, 0, mips_pkg::fn_srlv),
                encode_rtype(0, 0, 0, 0, mips_pkg::fn_jr),
                32'h0000_0000};
        load_program(prog, '0, '0);
        reset_dut();
        repeat (12) @(negedge clk);
        check_bit("active", active, 1'b1);
        reset_dut();
        check_word("register_v0", register_v0, 32'h0000_0000);
        wait_halt();
        check_word("register_v0", register_v0, 32'h0000_0002);
    endtask

    task automatic run_all_tests();
        test_reference();
        test_alu_ops();
        test_load_store();
        test_delay_slot();
        test_reset_mid_run();
    endtask

    initial begin
        run_all_tests();
        @(posedge clk);
        stall_en <= 1'b1;
        run_all_tests();
        check_bit("waitrequest stall seen", stall_cycles != 0, 1'b1);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: mips_cpu.f
mips_pkg.sv
mips_alu.sv
mips_regfile.sv
mips_pc.sv
mips_fsm.sv
mips_cpu.sv
avalon_ram_model.sv
mips_cpu_assertions.sv
mips_cpu_tb.sv

// File: Bender.yml
package:
  name: mips_cpu

sources:
  - mips_pkg.sv
  - mips_alu.sv
  - mips_regfile.sv
  - mips_pc.sv
  - mips_fsm.sv
  - mips_cpu.sv
  - target: test
    files:
      - avalon_ram_model.sv
      - mips_cpu_assertions.sv
      - mips_cpu_tb.sv
